//--- flash_image.hex
// one 16-bit word per line, low byte holds the even byte address
// words 0 to 15 are the flash image, words 16 to 23 the SFDP table
4140
4342
4544
4746
4948
4b4a
4d4c
4f4e
5150
5352
5554
5756
5958
5b5a
5d5c
5f5e
4653
5044
0106
ff00
0600
1001
0030
ff00

//--- all.f
verilog/flash_emu_pkg.sv
verilog/spi_byte_if.sv
verilog/mem_read_if.sv
verilog/spi_target_phy.sv
verilog/flash_command_engine.sv
verilog/flash_image_mem.sv
verilog/access_log_fifo.sv
verilog/flash_emu_top.sv
dv/flash_emu_tb.sv

//--- Bender.yml
package:
  name: flash_emu

sources:
  - files:
      - verilog/flash_emu_pkg.sv
      - verilog/spi_byte_if.sv
      - verilog/mem_read_if.sv
      - verilog/spi_target_phy.sv
      - verilog/flash_command_engine.sv
      - verilog/flash_image_mem.sv
      - verilog/access_log_fifo.sv
      - verilog/flash_emu_top.sv
  - target: test
    files:
      - dv/flash_emu_tb.sv

//--- dv/flash_emu_tb.sv
// ==================================================
// testbench for the SPI flash emulator
// a stimulus table is run through a SPI mode 0 host,
// MISO bytes, log entries and the error byte are
// checked against a model built from the hex image
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module flash_emu_tb;
	import flash_emu_pkg::*;

	localparam logic [31:0] SEED = 32'h6a44_9d01;

	// one table row per SPI transaction
	typedef struct packed {
		logic [7:0]  cmd;
		logic [23:0] addr;
		// bytes clocked after command, address and dummy
		logic [7:0]  len;
		// keep log_ready low across this row
		logic        hold;
		// sticky error byte expected once the row is done
		logic [7:0]  exp_err;
	} row_t;

	logic        clk = 1'b0;
	logic        reset;
	logic        sclk;
	logic        cs_n;
	logic        mosi;
	logic        miso;
	logic        log_valid;
	logic        log_ready;
	logic [7:0]  log_cmd;
	logic [23:0] log_addr;
	logic [7:0]  log_len;
	logic [7:0]  errors;

	row_t        rows[$];
	log_entry_t  exp_log[$];
	logic [15:0] image_words [MEM_WORDS];
	logic        wel_model;
	int          mismatch_count;
	int          fail_count;
	int          cycle_count;
	int          timeout_limit;
	int          seed_value;

	flash_emu_top flash_emu_top_inst (
		.clk       (clk),
		.reset     (reset),
		.sclk      (sclk),
		.cs_n      (cs_n),
		.mosi      (mosi),
		.miso      (miso),
		.log_valid (log_valid),
		.log_ready (log_ready),
		.log_cmd   (log_cmd),
		.log_addr  (log_addr),
		.log_len   (log_len),
		.errors    (errors)
	);

	always #20 clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("timeout: run did not finish within %0d cycles", timeout_limit);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic check_log(input log_entry_t got, input log_entry_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: log_entry got %h/%h/%h expected %h/%h/%h", $time,
				got.cmd, got.addr, got.len, exp.cmd, exp.addr, exp.len);
			mismatch_count++;
		end
	endtask

	task automatic check_errors(input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: errors got %h expected %h", $time, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic add_row(input logic [7:0] cmd, input logic [23:0] addr, input int len,
		input logic hold, input logic [7:0] exp_err);
		row_t r;
		r.cmd     = cmd;
		r.addr    = addr;
		r.len     = 8'(len);
		r.hold    = hold;
		r.exp_err = exp_err;
		rows.push_back(r);
	endtask

	// low byte of each word is the even address
	function automatic logic [7:0] flash_byte(input int b);
		logic [15:0] w;
		w = image_words[b / 2];
		return (b % 2) ? w[15:8] : w[7:0];
	endfunction

	// SFDP table starts right after the 32 flash bytes
	function automatic logic [7:0] sfdp_byte(input int b);
		return flash_byte(FLASH_BYTES + b);
	endfunction

	function automatic logic [7:0] status_byte(input logic wel);
		status_reg_u st;
		st.raw   = 8'h00;
		st.f.wel = wel;
		return st.raw;
	endfunction

	function automatic logic has_address(input logic [7:0] cmd);
		return (cmd == CMD_READ) || (cmd == CMD_SFDP) || (cmd == CMD_PP3) ||
			(cmd == CMD_ERASE);
	endfunction

	// command byte, three address bytes, SFDP dummy byte
	function automatic int header_bytes(input logic [7:0] cmd);
		if (cmd == CMD_SFDP)
			return 5;
		return has_address(cmd) ? 4 : 1;
	endfunction

	function automatic logic [7:0] request_byte(input row_t r, input int slot);
		if (slot == 0)
			return r.cmd;
		if (has_address(r.cmd) && slot <= 3)
			return r.addr[23 - 8 * (slot - 1) -: 8];
		// dummy and filler bytes carry the slot number
		return 8'(slot);
	endfunction

	// replies start one turnaround byte after the header
	function automatic logic [7:0] expected_miso(input row_t r, input int slot,
		input logic [7:0] status);
		int k;
		k = slot - header_bytes(r.cmd) - 1;
		if (k < 0)
			return 8'hff;
		case (r.cmd)
			CMD_READ: return flash_byte((int'(r.addr) + k) % FLASH_BYTES);
			CMD_SFDP: return sfdp_byte((int'(r.addr) + k) % SFDP_BYTES);
			CMD_RDSR: return status;
			CMD_RDID: return (k < 3) ? JEDEC_ID[23 - 8 * k -: 8] : 8'hff;
			default:  return 8'hff;
		endcase
	endfunction

	// one byte, msb first; called right after a rising clk
	task automatic shift_spi_byte(input logic [7:0] tx, output logic [7:0] rx);
		int i;
		for (i = 7; i >= 0; i--) begin
			mosi <= tx[i];
			sclk <= 1'b0;
			repeat (3) @(posedge clk);
			// MISO has settled by now, sample mid cycle
			@(negedge clk);
			rx[i] = miso;
			@(posedge clk);
			sclk <= 1'b1;
			repeat (4) @(posedge clk);
		end
	endtask

	task automatic wait_log_valid(output logic seen);
		int n;
		seen = 1'b0;
		for (n = 0; n < 40 && !seen; n++) begin
			@(negedge clk);
			if (log_valid)
				seen = 1'b1;
		end
	endtask

	// pop every outstanding entry through the valid/ready port
	task automatic drain_log();
		logic       seen;
		log_entry_t got;
		while (exp_log.size() > 0) begin
			wait_log_valid(seen);
			if (!seen) begin
				$display("log entry missing at %0t, %0d still expected", $time,
					exp_log.size());
				fail_count++;
				exp_log.delete();
			end else begin
				got = {log_cmd, log_addr, log_len};
				check_log(got, exp_log.pop_front());
				@(posedge clk);
				log_ready <= 1'b1;
				@(posedge clk);
				log_ready <= 1'b0;
			end
		end
	endtask

	task automatic run_transaction(input int idx);
		row_t       r;
		int         s;
		int         total;
		logic [7:0] rx;
		logic [7:0] status_now;
		log_entry_t entry;
		r          = rows[idx];
		total      = header_bytes(r.cmd) + int'(r.len);
		status_now = status_byte(wel_model);
		if (!r.hold)
			drain_log();
		cs_n <= 1'b0;
		repeat (4) @(posedge clk);
		for (s = 0; s < total; s++) begin
			shift_spi_byte(request_byte(r, s), rx);
			check_byte($sformatf("miso row %0d byte %0d", idx, s), rx,
				expected_miso(r, s, status_now));
		end
		sclk <= 1'b0;
		repeat (4) @(posedge clk);
		cs_n <= 1'b1;
		repeat (8) @(posedge clk);

		// write-enable latch
		case (r.cmd)
			CMD_WREN: wel_model = 1'b1;
			CMD_WRDS, CMD_PP3, CMD_ERASE: wel_model = 1'b0;
			default: ;
		endcase

		entry.cmd  = r.cmd;
		entry.addr = has_address(r.cmd) ? r.addr : 24'd0;
		entry.len  = r.len;
		// a full queue loses the entry
		if (exp_log.size() < LOG_DEPTH)
			exp_log.push_back(entry);
		if (!r.hold)
			drain_log();
		@(negedge clk);
		check_errors(errors, r.exp_err);
		@(posedge clk);
	endtask

	initial begin
		int idx;
		sclk           = 1'b0;
		cs_n           = 1'b1;
		mosi           = 1'b0;
		log_ready      = 1'b0;
		reset          = 1'b1;
		wel_model      = 1'b0;
		mismatch_count = 0;
		fail_count     = 0;
		cycle_count    = 0;
		seed_value     = $urandom(SEED);
		$readmemh("flash_image.hex", image_words);

		//      cmd        addr         len hold err
		add_row(CMD_RDSR,  24'h000000,  3, 1'b0, 8'h00);
		add_row(CMD_RDID,  24'h000000,  5, 1'b0, 8'h00);
		add_row(CMD_READ,  24'h000000,  6, 1'b0, 8'h00);
		// odd start, wraps past byte 31
		add_row(CMD_READ,  24'h00001d,  8, 1'b0, 8'h00);
		add_row(CMD_READ,  24'h120406,  4, 1'b0, 8'h00);
		add_row(CMD_SFDP,  24'h000000,  6, 1'b0, 8'h00);
		add_row(CMD_SFDP,  24'h00000b,  8, 1'b0, 8'h00);
		add_row(CMD_WREN,  24'h000000,  0, 1'b0, 8'h00);
		add_row(CMD_RDSR,  24'h000000,  3, 1'b0, 8'h00);
		add_row(CMD_WRDS,  24'h000000,  0, 1'b0, 8'h04);
		add_row(CMD_RDSR,  24'h000000,  3, 1'b0, 8'h04);
		add_row(CMD_WREN,  24'h000000,  0, 1'b0, 8'h04);
		add_row(CMD_PP3,   24'h000010,  2, 1'b0, 8'h04);
		add_row(CMD_RDSR,  24'h000000,  3, 1'b0, 8'h04);
		add_row(CMD_WREN,  24'h000000,  0, 1'b0, 8'h04);
		add_row(CMD_ERASE, 24'h001000,  0, 1'b0, 8'h04);
		add_row(CMD_RDSR,  24'h000000,  3, 1'b0, 8'h04);
		add_row(8'hab,     24'h000000,  3, 1'b0, 8'h0c);
		// five rows under back-pressure, the fifth entry is lost
		add_row(CMD_RDSR,  24'h000000,  1, 1'b1, 8'h0c);
		add_row(CMD_READ,  24'h000003,  3, 1'b1, 8'h0c);
		add_row(CMD_RDID,  24'h000000,  2, 1'b1, 8'h0c);
		add_row(CMD_WREN,  24'h000000,  0, 1'b1, 8'h0c);
		add_row(CMD_WRDS,  24'h000000,  0, 1'b1, 8'h0d);
		// random reads at the end
		repeat (4)
			add_row(CMD_READ, 24'($urandom()), 2 + ($urandom() % 11), 1'b0, 8'h0d);

		timeout_limit = rows.size() * 40 * 8 * 2 + 2000;

		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		check_errors(errors, 8'h00);
		if (log_valid !== 1'b0) begin
			$display("log_valid is not low after reset");
			fail_count++;
		end
		@(posedge clk);

		for (idx = 0; idx < rows.size(); idx++)
			run_transaction(idx);
		drain_log();
		@(negedge clk);
		if (log_valid !== 1'b0) begin
			$display("log queue holds an entry that no transaction produced");
			fail_count++;
		end

		$display("checks done: %0d mismatches, %0d other errors", mismatch_count, fail_count);
		if (mismatch_count == 0 && fail_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/flash_emu_top.sv
// ==================================================
// SPI NOR flash emulator top level
// SPI pins in, MISO and a log stream out, plus the
// sticky error byte
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module flash_emu_top (
	input  logic        clk,
	input  logic        reset,
	input  logic        sclk,
	input  logic        cs_n,
	input  logic        mosi,
	output logic        miso,
	output logic        log_valid,
	input  logic        log_ready,
	output logic [7:0]  log_cmd,
	output logic [23:0] log_addr,
	output logic [7:0]  log_len,
	output logic [7:0]  errors
);
	import flash_emu_pkg::*;

	spi_byte_if spi_bus ();
	mem_read_if mem_bus ();

	logic       log_push;
	log_entry_t log_entry;
	logic [7:0] engine_errors;
	logic       overflow;

	spi_target_phy spi_target_phy_inst (
		.clk   (clk),
		.reset (reset),
		.sclk  (sclk),
		.cs_n  (cs_n),
		.mosi  (mosi),
		.miso  (miso),
		.bus   (spi_bus.phy)
	);

	flash_command_engine flash_command_engine_inst (
		.clk       (clk),
		.reset     (reset),
		.bus       (spi_bus.engine),
		.mem       (mem_bus.engine),
		.log_push  (log_push),
		.log_entry (log_entry),
		.errors    (engine_errors)
	);

	flash_image_mem flash_image_mem_inst (
		.clk  (clk),
		.port (mem_bus.mem)
	);

	access_log_fifo access_log_fifo_inst (
		.clk       (clk),
		.reset     (reset),
		.push      (log_push),
		.entry     (log_entry),
		.log_valid (log_valid),
		.log_ready (log_ready),
		.log_cmd   (log_cmd),
		.log_addr  (log_addr),
		.log_len   (log_len),
		.overflow  (overflow)
	);

	// queue overflow lands in its own bit of the error byte
	assign errors = engine_errors | (8'(overflow) << ERR_LOG_OVERFLOW);

endmodule

`default_nettype wire

//--- verilog/access_log_fifo.sv
// ==================================================
// small queue for transaction log entries
// valid/ready on the output side, a push into a full
// queue is lost and raises a sticky overflow flag
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module access_log_fifo (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      push,
	input  flash_emu_pkg::log_entry_t entry,
	output logic                      log_valid,
	input  logic                      log_ready,
	output logic [7:0]                log_cmd,
	output logic [23:0]               log_addr,
	output logic [7:0]                log_len,
	output logic                      overflow
);
	import flash_emu_pkg::*;

	log_entry_t entries [LOG_DEPTH];

	logic [$clog2(LOG_DEPTH)-1:0]   wr_ptr;
	logic [$clog2(LOG_DEPTH)-1:0]   rd_ptr;
	logic [$clog2(LOG_DEPTH+1)-1:0] count;
	logic                           full;
	logic                           do_push;
	logic                           do_pop;

	assign full    = (count == LOG_DEPTH);
	assign do_push = push && !full;
	assign do_pop  = log_valid && log_ready;

	always_ff @(posedge clk) begin
		if (do_push)
			entries[wr_ptr] <= entry;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + do_push - do_pop;
			// entry is dropped
			if (push && full)
				overflow <= 1'b1;
		end
	end

	// head entry stays put until it is taken
	assign log_valid = (count != 0);
	assign log_cmd   = entries[rd_ptr].cmd;
	assign log_addr  = entries[rd_ptr].addr;
	assign log_len   = entries[rd_ptr].len;

endmodule

`default_nettype wire

//--- verilog/flash_image_mem.sv
// ==================================================
// backing word memory, flash image then SFDP table
// contents come from the hex image at start of sim
// data is valid two cycles after read_enable rises
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module flash_image_mem (
	input  logic    clk,
	mem_read_if.mem port
);
	import flash_emu_pkg::*;

	logic [15:0] words [MEM_WORDS];

	logic        en_q1;
	logic        en_q2;
	logic [15:0] data_q;

	initial begin
		$readmemh("flash_image.hex", words);
	end

	// enable pipeline, a low enable restarts it
	always_ff @(posedge clk) begin
		en_q1 <= port.read_enable;
		en_q2 <= en_q1 && port.read_enable;
	end

	// registered read, second stage lines up with valid
	always_ff @(posedge clk) begin
		data_q         <= words[port.word_addr];
		port.read_data <= data_q;
	end

	assign port.read_valid = en_q2;

endmodule

`default_nettype wire

//--- verilog/flash_command_engine.sv
// ==================================================
// JEDEC command engine for the emulated flash
// decodes the command byte, collects the address,
// streams read data from the word memory and emits
// one log entry when chip select goes away
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module flash_command_engine (
	input  logic                     clk,
	input  logic                     reset,
	spi_byte_if.engine               bus,
	mem_read_if.engine               mem,
	output logic                     log_push,
	output flash_emu_pkg::log_entry_t log_entry,
	output logic [7:0]               errors
);
	import flash_emu_pkg::*;

	logic [7:0]  cmd;
	logic        cmd_valid;
	// bytes seen after the command, stops at hdr_len
	logic [2:0]  hdr_cnt;
	logic [2:0]  hdr_len;
	logic [23:0] addr;
	logic [23:0] next_addr;
	logic [7:0]  len;
	status_reg_u status;

	logic        is_sfdp;
	logic        is_read;
	logic        has_addr;

	// byte offset inside the current region
	logic [$clog2(FLASH_BYTES)-1:0] cur_byte;
	logic [$clog2(FLASH_BYTES)-1:0] byte_mask;
	logic [$clog2(FLASH_BYTES)-1:0] start_byte;
	logic [7:0]                     sel_byte;

	assign is_sfdp  = (cmd == CMD_SFDP);
	assign is_read  = (cmd == CMD_READ) || is_sfdp;
	assign has_addr = is_read || (cmd == CMD_PP3) || (cmd == CMD_ERASE);
	// SFDP carries one dummy byte after the address
	assign hdr_len  = is_sfdp ? 3'd4 : (has_addr ? 3'd3 : 3'd0);

	assign next_addr = {addr[15:0], bus.rx_data};

	assign byte_mask = is_sfdp ? SFDP_BYTES[$clog2(FLASH_BYTES)-1:0] - 1'b1
		: FLASH_BYTES[$clog2(FLASH_BYTES)-1:0] - 1'b1;
	// the dummy byte is not part of the SFDP address
	assign start_byte = (is_sfdp ? addr[$clog2(FLASH_BYTES)-1:0]
		: next_addr[$clog2(FLASH_BYTES)-1:0]) & byte_mask;

	// SFDP words sit right above the flash image
	assign mem.word_addr = MEM_ADDR_BITS'((is_sfdp ? FLASH_BYTES / 2 : 0) + (cur_byte >> 1));
	assign sel_byte = cur_byte[0] ? mem.read_data[15:8] : mem.read_data[7:0];

	always_ff @(posedge clk) begin
		bus.tx_strobe <= 1'b0;
		log_push      <= 1'b0;
		if (reset) begin
			cmd_valid       <= 1'b0;
			hdr_cnt         <= 3'd0;
			len             <= 8'd0;
			mem.read_enable <= 1'b0;
			status.raw      <= 8'h00;
			errors          <= 8'h00;
		end else begin
			if (!bus.cs_active) begin
				cmd_valid       <= 1'b0;
				hdr_cnt         <= 3'd0;
				mem.read_enable <= 1'b0;
				// one entry per transaction that got a command byte
				if (cmd_valid) begin
					log_push       <= 1'b1;
					log_entry.cmd  <= cmd;
					log_entry.addr <= has_addr ? addr : 24'd0;
					log_entry.len  <= len;
				end
			end else if (bus.rx_cmd) begin
				cmd       <= bus.rx_data;
				cmd_valid <= 1'b1;
				hdr_cnt   <= 3'd0;
				len       <= 8'd0;
				addr      <= 24'd0;
				case (bus.rx_data)
					CMD_RDSR: begin
						bus.tx_data   <= status.raw;
						bus.tx_strobe <= 1'b1;
					end
					CMD_RDID: begin
						bus.tx_data   <= JEDEC_ID[23:16];
						bus.tx_strobe <= 1'b1;
					end
					CMD_WREN: begin
						status.f.wel <= 1'b1;
					end
					CMD_WRDS, CMD_PP3, CMD_ERASE: begin
						// no program or erase here, only the latch drops
						status.f.wel          <= 1'b0;
						errors[ERR_WRITE_CMD] <= 1'b1;
					end
					CMD_READ, CMD_SFDP: begin
						// address bytes follow
					end
					default: begin
						errors[ERR_UNKNOWN_CMD] <= 1'b1;
					end
				endcase
			end else if (cmd_valid) begin
				// shift register loads at this boundary, a read still
				// in flight has missed its slot
				if (bus.rx_bit_strobe && bus.rx_bit == 3'd7 && mem.read_enable)
					errors[ERR_LATE_DATA] <= 1'b1;

				if (bus.rx_strobe) begin
					if (hdr_cnt < hdr_len) begin
						hdr_cnt <= hdr_cnt + 3'd1;
						if (hdr_cnt < 3'd3)
							addr <= next_addr;
						// last address or dummy byte starts the first fetch
						if (is_read && hdr_cnt == hdr_len - 3'd1) begin
							cur_byte        <= start_byte;
							mem.read_enable <= 1'b1;
						end
					end else begin
						len <= len + 8'd1;
						if (cmd == CMD_RDSR) begin
							bus.tx_data   <= status.raw;
							bus.tx_strobe <= 1'b1;
						end else if (cmd == CMD_RDID && len < 8'd2) begin
							bus.tx_data   <= (len == 8'd0) ? JEDEC_ID[15:8] : JEDEC_ID[7:0];
							bus.tx_strobe <= 1'b1;
						end else if (is_read && !mem.read_enable) begin
							mem.read_enable <= 1'b1;
						end
					end
				end

				// word arrived, pick the byte and step to the next address
				if (mem.read_enable && mem.read_valid) begin
					bus.tx_data     <= sel_byte;
					bus.tx_strobe   <= 1'b1;
					mem.read_enable <= 1'b0;
					cur_byte        <= (cur_byte + 1'b1) & byte_mask;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/spi_target_phy.sv
// ==================================================
// SPI mode 0 target front end
// oversamples the pins, emits byte and bit events and
// shifts the queued reply byte out on MISO
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module spi_target_phy (
	input  logic       clk,
	input  logic       reset,
	input  logic       sclk,
	input  logic       cs_n,
	input  logic       mosi,
	output logic       miso,
	spi_byte_if.phy    bus
);

	// two synchronizer stages, third sclk stage for edges
	logic [2:0] sclk_q;
	logic [1:0] cs_q;
	logic [1:0] mosi_q;

	logic       sclk_rise;
	logic       sclk_fall;
	logic       cs_sel;
	logic       byte_end;

	logic [2:0] bit_cnt;
	logic       first_byte;
	logic [7:0] pending;
	logic       pending_valid;
	logic [7:0] shift_reg;

	always_ff @(posedge clk) begin
		if (reset) begin
			sclk_q <= 3'b000;
			cs_q   <= 2'b11;
			mosi_q <= 2'b00;
		end else begin
			sclk_q <= {sclk_q[1:0], sclk};
			cs_q   <= {cs_q[0], cs_n};
			mosi_q <= {mosi_q[0], mosi};
		end
	end

	assign sclk_rise = sclk_q[1] & ~sclk_q[2];
	assign sclk_fall = ~sclk_q[1] & sclk_q[2];
	assign cs_sel    = ~cs_q[1];
	// last bit of a byte arrives on this edge
	assign byte_end  = cs_sel && sclk_rise && (bit_cnt == 3'd7);

	assign bus.cs_active = cs_sel;

	// receive side, msb first
	always_ff @(posedge clk) begin
		bus.rx_cmd        <= 1'b0;
		bus.rx_strobe     <= 1'b0;
		bus.rx_bit_strobe <= 1'b0;
		if (reset) begin
			bit_cnt    <= 3'd0;
			first_byte <= 1'b1;
		end else if (!cs_sel) begin
			bit_cnt    <= 3'd0;
			first_byte <= 1'b1;
		end else if (sclk_rise) begin
			bus.rx_data       <= {bus.rx_data[6:0], mosi_q[1]};
			bus.rx_bit        <= bit_cnt;
			bus.rx_bit_strobe <= 1'b1;
			bit_cnt           <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7) begin
				first_byte <= 1'b0;
				if (first_byte)
					bus.rx_cmd <= 1'b1;
				else
					bus.rx_strobe <= 1'b1;
			end
		end
	end

	// transmit side
	// a byte queued during one slot is shifted out during the next,
	// an empty slot sends FF
	always_ff @(posedge clk) begin
		if (reset) begin
			pending_valid <= 1'b0;
			shift_reg     <= 8'hff;
			miso          <= 1'b1;
		end else if (!cs_sel) begin
			pending_valid <= 1'b0;
			shift_reg     <= 8'hff;
			miso          <= 1'b1;
		end else if (byte_end) begin
			if (bus.tx_strobe)
				shift_reg <= bus.tx_data;
			else
				shift_reg <= pending_valid ? pending : 8'hff;
			pending_valid <= 1'b0;
		end else begin
			// later load in the same slot wins
			if (bus.tx_strobe) begin
				pending       <= bus.tx_data;
				pending_valid <= 1'b1;
			end
			if (sclk_fall) begin
				miso      <= shift_reg[7];
				shift_reg <= {shift_reg[6:0], 1'b1};
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/mem_read_if.sv
// ==================================================
// word read port between the command engine and the
// backing memory, fixed two-cycle read latency
// ==================================================
`timescale 1ns/1ps
`default_nettype none

interface mem_read_if;
	import flash_emu_pkg::*;

	logic                     read_enable;
	logic [MEM_ADDR_BITS-1:0] word_addr;
	// low byte holds the even address
	logic [15:0]              read_data;
	logic                     read_valid;

	modport engine (
		output read_enable, word_addr,
		input  read_data, read_valid
	);

	modport mem (
		input  read_enable, word_addr,
		output read_data, read_valid
	);

endinterface

`default_nettype wire

//--- verilog/spi_byte_if.sv
// ==================================================
// byte and bit events from the SPI front end, and
// transmit bytes going back to it
// ==================================================
`timescale 1ns/1ps
`default_nettype none

interface spi_byte_if;

	logic       cs_active;
	// shifts in one bit per sclk rising edge
	logic [7:0] rx_data;
	// first byte of a transaction
	logic       rx_cmd;
	// every later byte
	logic       rx_strobe;
	logic [2:0] rx_bit;
	logic       rx_bit_strobe;
	// byte for the next slot on MISO
	logic [7:0] tx_data;
	logic       tx_strobe;

	modport phy (
		output cs_active, rx_data, rx_cmd, rx_strobe, rx_bit, rx_bit_strobe,
		input  tx_data, tx_strobe
	);

	modport engine (
		input  cs_active, rx_data, rx_cmd, rx_strobe, rx_bit, rx_bit_strobe,
		output tx_data, tx_strobe
	);

endinterface

`default_nettype wire

//--- verilog/flash_emu_pkg.sv
// ==================================================
// shared definitions for the SPI flash emulator
// command codes, memory sizes, status register and
// log entry layout; modules import what they need
// ==================================================
`default_nettype none

package flash_emu_pkg;

	// JEDEC command bytes
	localparam logic [7:0] CMD_PP3   = 8'h02;
	localparam logic [7:0] CMD_READ  = 8'h03;
	localparam logic [7:0] CMD_WRDS  = 8'h04;
	localparam logic [7:0] CMD_RDSR  = 8'h05;
	localparam logic [7:0] CMD_WREN  = 8'h06;
	localparam logic [7:0] CMD_ERASE = 8'h20;
	localparam logic [7:0] CMD_SFDP  = 8'h5a;
	localparam logic [7:0] CMD_RDID  = 8'h9f;

	// manufacturer, type, capacity
	localparam logic [23:0] JEDEC_ID = 24'hc2_20_18;

	// flash image first, SFDP table right after it
	localparam int FLASH_BYTES   = 32;
	localparam int SFDP_BYTES    = 16;
	localparam int MEM_WORDS     = 24;
	localparam int MEM_ADDR_BITS = 5;

	localparam int LOG_DEPTH = 4;

	// bit positions in the sticky error byte
	localparam int ERR_LOG_OVERFLOW = 0;
	localparam int ERR_LATE_DATA    = 1;
	localparam int ERR_WRITE_CMD    = 2;
	localparam int ERR_UNKNOWN_CMD  = 3;

	// field order follows the datasheet, srp0 is the msb
	typedef struct packed {
		logic       srp0;
		logic       tb;
		logic [3:0] bp;
		logic       wel;
		logic       busy;
	} status_fields_t;

	typedef union packed {
		logic [7:0]     raw;
		status_fields_t f;
	} status_reg_u;

	typedef struct packed {
		logic [7:0]  cmd;
		logic [23:0] addr;
		logic [7:0]  len;
	} log_entry_t;

endpackage

`default_nettype wire
